//--- verilog.f
+incdir+common
+incdir+bench
common/mipsIsaPkg.sv
common/mipsCtrlPkg.sv
src/mipsAlu.sv
src/mipsRegFile.sv
src/mipsDatapath.sv
src/mipsControl.sv
src/multiCycleMips.sv
bench/mipsTb.sv

//--- run.sh
#!/bin/sh
# Build and run the multi-cycle MIPS testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module mipsTb \
   -Mdir obj_dir -o mipsSim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/mipsSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
   exit 1
fi
if [ $simStatus -ne 0 ]; then
   echo "simulation exited with status $simStatus"
   exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
   echo "no result line in $LOG"
   exit 1
fi
exit 0

//--- bench/mipsTbRef.svh
`ifndef MIPS_TB_REF_SVH
`define MIPS_TB_REF_SVH

// ----------------------------------------------------------------------------
// reference model, included into the testbench module
// ----------------------------------------------------------------------------
word_t shadowRegs [`MIPS_NREGS];   // architectural state as the ISA defines it

// 32-bit xorshift, shifts 13, 17, 5
function automatic word_t xorshift32(input word_t x);
   word_t y;
   y = x ^ (x << 13);
   y = y ^ (y >> 17);
   y = y ^ (y << 5);
   return y;
endfunction

// result of one R-format or I-format ALU instruction
function automatic word_t refAlu(input word_t insn, input word_t rsVal, input word_t rtVal);
   word_t sext;
   word_t zext;
   sext = {{16{insn[15]}}, insn[15:0]};
   zext = {16'h0000, insn[15:0]};
   case (opcode_e'(insn[31:26]))
      rFormat: begin
         case (funct_e'(insn[5:0]))
            fAdd, fAddu: return rsVal + rtVal;
            fSub, fSubu: return rsVal - rtVal;
            fAnd:        return rsVal & rtVal;
            fOr:         return rsVal | rtVal;
            fXor:        return rsVal ^ rtVal;
            fNor:        return ~(rsVal | rtVal);
            fSlt:        return word_t'($signed(rsVal) < $signed(rtVal));
            fSltu:       return word_t'(rsVal < rtVal);
            default:     return '0;
         endcase
      end
      addi, addiu: return rsVal + sext;
      slti:        return word_t'($signed(rsVal) < $signed(sext));
      sltiu:       return word_t'(rsVal < zext);   // zero-extended here
      andi:        return rsVal & zext;
      ori:         return rsVal | zext;
      xori:        return rsVal ^ zext;
      lui:         return {insn[15:0], 16'h0000};
      default:     return '0;
   endcase
endfunction

function automatic word_t readShadow(input regIdx_t r);
   return (r == '0) ? '0 : shadowRegs[r];
endfunction

function automatic void writeShadow(input regIdx_t r, input word_t v);
   if (r != '0)
      shadowRegs[r] = v;   // register 0 ignores writes
endfunction

`endif

//--- bench/mipsTb.sv
`include "mips_consts.svh"

module mipsTb
   import mipsIsaPkg::*;
();

   localparam int      ClkPeriod = 40;
   localparam int      MixLength = 40;
   localparam word_t   DataBase  = 32'h0000_0800;   // data region, above the program
   localparam regIdx_t BaseReg   = 5'd16;           // holds DataBase, never overwritten

   logic  clk;
   logic  reset;
   word_t memReadData;
   word_t memAddr;
   word_t memWriteData;
   logic  memRead;
   logic  memWrite;

   word_t       mem [1024];
   word_t       expAddr [$];
   word_t       expData [$];
   word_t       rng;
   logic [15:0] lastSlot;
   int          progLen;
   int          stepsRun;
   int          storesSeen;
   int          storesTotal;
   logic        modelReady;

   `include "mipsTbRef.svh"

   multiCycleMips dut0 (
      .clk          (clk),
      .reset        (reset),
      .memReadData  (memReadData),
      .memAddr      (memAddr),
      .memWriteData (memWriteData),
      .memRead      (memRead),
      .memWrite     (memWrite)
   );

   always #(ClkPeriod / 2) clk = ~clk;

   // ----------------------------------------------------------------------------
   // memory model
   // ----------------------------------------------------------------------------
   assign memReadData = mem[memAddr[11:2]];   // answers at once, well inside the latency

   always @(posedge clk) begin
      if (memWrite)
         mem[memAddr[11:2]] <= memWriteData;
   end

   function automatic word_t fillWord(input logic [9:0] idx);
      return (word_t'(idx) * 32'h9E37_79B9) ^ 32'h0F0F_5A5A;
   endfunction

   // ----------------------------------------------------------------------------
   // program generation
   // ----------------------------------------------------------------------------
   function automatic word_t drawRandom();
      rng = xorshift32(rng);
      return rng;
   endfunction

   function automatic regIdx_t pickReg();
      word_t r;
      r = drawRandom();
      return {1'b0, r[3:0]};   // registers 0 to 15
   endfunction

   function automatic funct_e functFor(input word_t r);
      case (r % 10)
         0:       return fAdd;
         1:       return fAddu;
         2:       return fSub;
         3:       return fSubu;
         4:       return fAnd;
         5:       return fOr;
         6:       return fXor;
         7:       return fNor;
         8:       return fSlt;
         default: return fSltu;
      endcase
   endfunction

   function automatic opcode_e immOpFor(input word_t r);
      case (r % 8)
         0:       return addi;
         1:       return addiu;
         2:       return slti;
         3:       return sltiu;
         4:       return andi;
         5:       return ori;
         6:       return xori;
         default: return lui;
      endcase
   endfunction

   function automatic word_t encR(input funct_e f, input regIdx_t rd, input regIdx_t rs,
                                  input regIdx_t rt);
      return {rFormat, rs, rt, rd, 5'b00000, f};
   endfunction

   function automatic word_t encI(input opcode_e op, input regIdx_t rt, input regIdx_t rs,
                                  input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic word_t encJ(input word_t target);
      return {jump, target[27:2]};
   endfunction

   task automatic placeInsn(input word_t insn);
      mem[progLen[9:0]] = insn;
      progLen++;
   endtask

   task automatic placeStore();
      word_t r;
      r = drawRandom();
      lastSlot = {9'b0, r[4:0], 2'b00};
      placeInsn(encI(sw, pickReg(), BaseReg, lastSlot));
   endtask

   task automatic buildProgram();
      word_t   r;
      regIdx_t a;
      regIdx_t b;
      int      i;
      progLen = 0;
      for (i = 1; i < 16; i++) begin
         r = drawRandom();
         if (i == 1)
            r[31] = 1'b1;   // r1 negative, r2 positive
         if (i == 2)
            r[31] = 1'b0;
         placeInsn(encI(lui, regIdx_t'(i), 5'd0, r[31:16]));
         placeInsn(encI(ori, regIdx_t'(i), regIdx_t'(i), r[15:0]));
      end
      placeInsn(encI(ori, BaseReg, 5'd0, DataBase[15:0]));
      placeInsn(encR(fSlt, 5'd17, 5'd1, 5'd2));
      placeInsn(encR(fSltu, 5'd18, 5'd1, 5'd2));
      placeInsn(encI(addi, 5'd0, 5'd1, 16'h0005));   // r0 has to stay zero

      for (i = 0; i < MixLength; i++) begin
         r = drawRandom();
         case (r % 8)
            0, 1: placeInsn(encR(functFor(drawRandom()), pickReg(), pickReg(), pickReg()));
            2, 3: placeInsn(encI(immOpFor(drawRandom()), pickReg(), pickReg(), r[31:16]));
            4:    placeStore();
            5: begin                  // load back what was just stored
               placeStore();
               placeInsn(encI(lw, pickReg(), BaseReg, lastSlot));
            end
            6: begin                  // branch over two stores
               a = pickReg();
               b = r[8] ? a : pickReg();
               if (r[9])
                  placeInsn(encI(beq, b, a, 16'd2));
               else
                  placeInsn(encI(bne, b, a, 16'd2));
               placeStore();
               placeStore();
            end
            default: begin            // jump over two stores
               placeInsn(encJ(word_t'((progLen + 3) * 4)));
               placeStore();
               placeStore();
            end
         endcase
      end

      for (i = 0; i <= 18; i++)
         placeInsn(encI(sw, regIdx_t'(i), BaseReg, 16'h0100 + 16'(i * 4)));
      placeInsn(encJ(word_t'(progLen * 4)));   // park here
   endtask

   // walk the program through the reference, collecting the stores in order
   task automatic runModel();
      word_t pc;
      word_t insnPc;
      word_t insn;
      word_t a;
      word_t b;
      word_t addr;
      word_t target;
      word_t refData [word_t];
      logic  done;
      pc = `MIPS_RESET_PC;
      done = 1'b0;
      stepsRun = 0;
      while (!done && stepsRun < 10000) begin
         insnPc = pc;
         insn = mem[pc[11:2]];
         a = readShadow(insn[25:21]);
         b = readShadow(insn[20:16]);
         addr = a + {{16{insn[15]}}, insn[15:0]};
         pc = pc + `MIPS_PC_STEP;
         stepsRun++;
         case (opcode_e'(insn[31:26]))
            rFormat: writeShadow(insn[15:11], refAlu(insn, a, b));
            addi, addiu, slti, sltiu, andi, ori, xori, lui:
               writeShadow(insn[20:16], refAlu(insn, a, b));
            lw: writeShadow(insn[20:16], refData.exists(addr) ? refData[addr] : fillWord(addr[11:2]));
            sw: begin
               refData[addr] = b;
               expAddr.push_back(addr);
               expData.push_back(b);
            end
            beq: if (a == b) pc = pc + ({{16{insn[15]}}, insn[15:0]} << 2);
            bne: if (a != b) pc = pc + ({{16{insn[15]}}, insn[15:0]} << 2);
            jump: begin
               target = {pc[31:28], insn[25:0], 2'b00};
               done = (target == insnPc);
               pc = target;
            end
            default: done = 1'b1;
         endcase
      end
   endtask

   // ----------------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------------
   task automatic stopWithFailure();
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic checkAddr(input string name, input word_t got, input word_t expected);
      if (got !== expected) begin
         $display("Mismatch %s: got %h expected %h", name, got, expected);
         stopWithFailure();
      end
   endtask

   task automatic checkData(input string name, input word_t got, input word_t expected);
      if (got !== expected) begin
         $display("Mismatch %s (store %0d): got %h expected %h", name, storesSeen, got,
                  expected);
         stopWithFailure();
      end
   endtask

   // each store is compared where the bus is stable
   always @(negedge clk) begin
      if (!reset && memWrite) begin
         if (storesSeen >= storesTotal) begin
            $display("unexpected store to %h after all expected stores", memAddr);
            stopWithFailure();
         end
         else begin
            checkAddr("memAddr", memAddr, expAddr.pop_front());
            checkData("memWriteData", memWriteData, expData.pop_front());
            storesSeen++;
         end
      end
   end

   // first access after reset is the fetch from the reset PC
   initial begin
      @(negedge reset);
      @(negedge clk);
      while (!memRead)
         @(negedge clk);
      checkAddr("memAddr", memAddr, `MIPS_RESET_PC);
   end

   initial begin
      wait (modelReady);
      repeat (stepsRun * 9 + 105) @(posedge clk);
      $display("timeout: only %0d of %0d stores arrived", storesSeen, storesTotal);
      stopWithFailure();
   end

   initial begin
      int i;
      clk = 1'b0;
      reset = 1'b1;
      modelReady = 1'b0;
      storesSeen = 0;
      rng = 32'd72172;
      lastSlot = '0;
      for (i = 0; i < 1024; i++)
         mem[i[9:0]] = fillWord(i[9:0]);
      buildProgram();
      runModel();
      storesTotal = expAddr.size();
      modelReady = 1'b1;
      repeat (5) @(posedge clk);
      #2 reset = 1'b0;
      wait (storesSeen == storesTotal);
      repeat (20) @(posedge clk);   // any stray store shows up here
      $display("RESULT: PASS");
      $finish;
   end

endmodule

//--- src/multiCycleMips.sv
module multiCycleMips
   import mipsIsaPkg::*, mipsCtrlPkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  word_t memReadData,
   output word_t memAddr,
   output word_t memWriteData,
   output logic  memRead,
   output logic  memWrite
);

   word_t    ir;
   logic     aluZero;
   logic     pcWrite, pcJump, irWrite, abWrite, mdrWrite, marWrite, regWrite;
   logic     signExt, memToReg, regDst;
   logic     setRead, clrRead, setWrite, clrWrite;
   marSrc_e  marSel;
   aluSrcA_e aluSelA;
   aluSrcB_e aluSelB;
   aluOp_e   aluOp;

   mipsControl ctrl0 (
      .clk      (clk),
      .reset    (reset),
      .ir       (ir),
      .aluZero  (aluZero),
      .pcWrite  (pcWrite),
      .pcJump   (pcJump),
      .irWrite  (irWrite),
      .abWrite  (abWrite),
      .mdrWrite (mdrWrite),
      .marWrite (marWrite),
      .regWrite (regWrite),
      .marSel   (marSel),
      .aluSelA  (aluSelA),
      .aluSelB  (aluSelB),
      .signExt  (signExt),
      .aluOp    (aluOp),
      .memToReg (memToReg),
      .regDst   (regDst),
      .setRead  (setRead),
      .clrRead  (clrRead),
      .setWrite (setWrite),
      .clrWrite (clrWrite)
   );

   mipsDatapath dp0 (
      .clk          (clk),
      .reset        (reset),
      .pcWrite      (pcWrite),
      .pcJump       (pcJump),
      .irWrite      (irWrite),
      .abWrite      (abWrite),
      .mdrWrite     (mdrWrite),
      .marWrite     (marWrite),
      .regWrite     (regWrite),
      .marSel       (marSel),
      .aluSelA      (aluSelA),
      .aluSelB      (aluSelB),
      .signExt      (signExt),
      .aluOp        (aluOp),
      .memToReg     (memToReg),
      .regDst       (regDst),
      .setRead      (setRead),
      .clrRead      (clrRead),
      .setWrite     (setWrite),
      .clrWrite     (clrWrite),
      .ir           (ir),
      .aluZero      (aluZero),
      .memAddr      (memAddr),
      .memWriteData (memWriteData),
      .memReadData  (memReadData),
      .memRead      (memRead),
      .memWrite     (memWrite)
   );

endmodule

//--- src/mipsControl.sv
module mipsControl
   import mipsIsaPkg::*, mipsCtrlPkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  word_t    ir,
   input  logic     aluZero,
   output logic     pcWrite,
   output logic     pcJump,
   output logic     irWrite,
   output logic     abWrite,
   output logic     mdrWrite,
   output logic     marWrite,
   output logic     regWrite,
   output marSrc_e  marSel,
   output aluSrcA_e aluSelA,
   output aluSrcB_e aluSelB,
   output logic     signExt,
   output aluOp_e   aluOp,
   output logic     memToReg,
   output logic     regDst,
   output logic     setRead,
   output logic     clrRead,
   output logic     setWrite,
   output logic     clrWrite
);

   ctrlState_e state, nextState;
   opcode_e    opcode;
   funct_e     funct;
   aluOp_e     rAluOp, iAluOp;
   logic       iSignExt;
   logic       branchTaken;
   logic       goFetch;      // load MAR with PC and start the next fetch

   assign opcode = opcode_e'(ir[31:26]);
   assign funct  = funct_e'(ir[5:0]);

   // beq and bne are the only opcodes reaching exBra1
   assign branchTaken = (opcode == beq) ? aluZero : !aluZero;

   always_ff @(posedge clk) begin
      if (reset) state <= rst;
      else state <= nextState;
   end

   // ---------------------------------------------------------------------------
   // ALU operation and immediate extension per instruction
   // ---------------------------------------------------------------------------
   always_comb begin
      case (funct)
         fAdd, fAddu: rAluOp = opAdd;
         fSub, fSubu: rAluOp = opSub;
         fAnd:        rAluOp = opAnd;
         fOr:         rAluOp = opOr;
         fXor:        rAluOp = opXor;
         fNor:        rAluOp = opNor;
         fSlt:        rAluOp = opSlt;
         fSltu:       rAluOp = opSltu;
         default:     rAluOp = opAdd;
      endcase
   end

   always_comb begin
      iSignExt = 1'b0;   // logic immediates and sltiu zero-extend
      case (opcode)
         addi, addiu: begin
            iAluOp   = opAdd;
            iSignExt = 1'b1;
         end
         slti: begin
            iAluOp   = opSlt;
            iSignExt = 1'b1;
         end
         sltiu:   iAluOp = opSltu;
         andi:    iAluOp = opAnd;
         ori:     iAluOp = opOr;
         xori:    iAluOp = opXor;
         lui:     iAluOp = opLui;
         default: iAluOp = opAdd;
      endcase
   end

   // ---------------------------------------------------------------------------
   // state machine
   // ---------------------------------------------------------------------------
   always_comb begin
      nextState = state;
      goFetch   = 1'b0;
      pcWrite   = 1'b0;
      pcJump    = 1'b0;
      irWrite   = 1'b0;
      abWrite   = 1'b0;
      mdrWrite  = 1'b0;
      marWrite  = 1'b0;
      regWrite  = 1'b0;
      setRead   = 1'b0;
      clrRead   = 1'b0;
      setWrite  = 1'b0;
      clrWrite  = 1'b0;
      marSel    = marPc;
      aluSelA   = srcPc;
      aluSelB   = srcRegB;
      aluOp     = opAdd;
      signExt   = 1'b0;
      memToReg  = 1'b0;
      regDst    = 1'b0;

      case (state)
         rst:    goFetch = 1'b1;
         fetch1: nextState = fetch2;
         fetch2: nextState = fetch3;
         fetch3: begin         // word is on the bus by now
            irWrite   = 1'b1;
            pcWrite   = 1'b1;
            clrRead   = 1'b1;
            aluSelB   = srcFour;
            nextState = decode;
         end
         decode: begin
            abWrite = 1'b1;
            case (opcode)
               rFormat: begin
                  case (funct)
                     fAdd, fAddu, fSub, fSubu, fAnd, fOr, fXor, fNor, fSlt, fSltu:
                        nextState = exAluR;
                     default: nextState = halt;
                  endcase
               end
               addi, addiu, slti, sltiu, andi, ori, xori, lui: nextState = exAluI;
               lw:       nextState = exLw1;
               sw:       nextState = exSw1;
               beq, bne: nextState = exBra1;
               jump:     nextState = exJump;
               default:  nextState = halt;
            endcase
         end
         exAluR: begin
            regWrite = 1'b1;
            aluSelA  = srcRegA;
            aluOp    = rAluOp;
            regDst   = 1'b1;
            goFetch  = 1'b1;
         end
         exAluI: begin
            regWrite = 1'b1;
            aluSelA  = srcRegA;
            aluSelB  = srcImm;
            aluOp    = iAluOp;
            signExt  = iSignExt;
            goFetch  = 1'b1;
         end
         exLw1, exSw1: begin      // effective address into MAR
            aluSelA  = srcRegA;
            aluSelB  = srcImm;
            signExt  = 1'b1;
            marSel   = marAlu;
            marWrite = 1'b1;
            setRead  = (state == exLw1);
            setWrite = (state == exSw1);
            nextState = (state == exLw1) ? exLw2 : exSw2;
         end
         exLw2: nextState = exLw3;
         exLw3: nextState = exLw4;
         exLw4: begin
            clrRead   = 1'b1;
            mdrWrite  = 1'b1;
            nextState = exLw5;
         end
         exLw5: begin
            regWrite = 1'b1;
            memToReg = 1'b1;
            goFetch  = 1'b1;
         end
         exSw2: begin
            clrWrite  = 1'b1;   // single write cycle
            nextState = exSw3;
         end
         exSw3: goFetch = 1'b1;
         exBra1: begin
            aluSelA = srcRegA;
            aluOp   = opSub;
            if (branchTaken) nextState = exBra2;
            else goFetch = 1'b1;
         end
         exBra2: begin          // pc already holds pc+4
            aluSelB   = srcImmShift;
            signExt   = 1'b1;
            pcWrite   = 1'b1;
            marSel    = marAlu;
            marWrite  = 1'b1;
            setRead   = 1'b1;
            nextState = fetch1;
         end
         exJump: begin
            pcJump    = 1'b1;
            marWrite  = 1'b1;
            setRead   = 1'b1;
            nextState = fetch1;
         end
         halt:    nextState = halt;
         default: nextState = halt;
      endcase

      if (goFetch) begin
         marSel    = marPc;
         marWrite  = 1'b1;
         setRead   = 1'b1;
         nextState = fetch1;
      end
   end

   // ---------------------------------------------------------------------------
   // checks
   // ---------------------------------------------------------------------------
   memReadWriteExclusive: assert property (@(posedge clk) disable iff (reset)
      !(setRead && setWrite));

   haltIsFinal: assert property (@(posedge clk) disable iff (reset)
      state == halt |=> state == halt);

endmodule

//--- src/mipsDatapath.sv
`include "mips_consts.svh"

module mipsDatapath
   import mipsIsaPkg::*, mipsCtrlPkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     pcWrite,
   input  logic     pcJump,
   input  logic     irWrite,
   input  logic     abWrite,
   input  logic     mdrWrite,
   input  logic     marWrite,
   input  logic     regWrite,
   input  marSrc_e  marSel,
   input  aluSrcA_e aluSelA,
   input  aluSrcB_e aluSelB,
   input  logic     signExt,
   input  aluOp_e   aluOp,
   input  logic     memToReg,
   input  logic     regDst,
   input  logic     setRead,
   input  logic     clrRead,
   input  logic     setWrite,
   input  logic     clrWrite,
   output word_t    ir,
   output logic     aluZero,
   output word_t    memAddr,
   output word_t    memWriteData,
   input  word_t    memReadData,
   output logic     memRead,
   output logic     memWrite
);

   word_t pc, regA, regB, mar, mdr;
   word_t rfA, rfB;
   word_t immExt, jumpTarget;
   word_t aluA, aluB, aluResult;

   // ---------------------------------------------------------------------------
   // operand forming
   // ---------------------------------------------------------------------------
   assign immExt     = signExt ? {{16{ir[15]}}, ir[15:0]} : {16'h0000, ir[15:0]};
   assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};   // stays in the current region

   assign aluA = (aluSelA == srcRegA) ? regA : pc;

   always_comb begin
      case (aluSelB)
         srcRegB:     aluB = regB;
         srcFour:     aluB = `MIPS_PC_STEP;
         srcImm:      aluB = immExt;
         srcImmShift: aluB = immExt << 2;
         default:     aluB = regB;
      endcase
   end

   // ---------------------------------------------------------------------------
   // architectural registers
   // ---------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset)
         pc <= `MIPS_RESET_PC;
      else if (pcWrite)
         pc <= aluResult;
      else if (pcJump)
         pc <= jumpTarget;
   end

   always_ff @(posedge clk) begin
      if (irWrite) ir <= memReadData;
      if (mdrWrite) mdr <= memReadData;
      if (abWrite) begin
         regA <= rfA;
         regB <= rfB;
      end
      if (marWrite)
         mar <= pcJump ? jumpTarget : (marSel == marAlu) ? aluResult : pc;
   end

   // memory strobes, clear wins over set
   always_ff @(posedge clk) begin
      if (reset || clrRead) memRead <= 1'b0;
      else if (setRead) memRead <= 1'b1;

      if (reset || clrWrite) memWrite <= 1'b0;
      else if (setWrite) memWrite <= 1'b1;
   end

   assign memAddr      = mar;
   assign memWriteData = regB;   // sw data from rt

   mipsAlu alu0 (
      .op     (aluOp),
      .a      (aluA),
      .b      (aluB),
      .result (aluResult),
      .zero   (aluZero)
   );

   mipsRegFile rf0 (
      .clk       (clk),
      .write     (regWrite),
      .rs        (ir[25:21]),
      .rt        (ir[20:16]),
      .rd        (ir[15:11]),
      .regDst    (regDst),
      .memToReg  (memToReg),
      .aluResult (aluResult),
      .mdr       (mdr),
      .rdA       (rfA),
      .rdB       (rfB)
   );

   // PC has one source per cycle
   pcSourceOne: assert property (@(posedge clk) disable iff (reset)
      !(pcWrite && pcJump));

endmodule

//--- src/mipsRegFile.sv
`include "mips_consts.svh"

module mipsRegFile
   import mipsIsaPkg::*;
(
   input  logic    clk,
   input  logic    write,
   input  regIdx_t rs,
   input  regIdx_t rt,
   input  regIdx_t rd,
   input  logic    regDst,
   input  logic    memToReg,
   input  word_t   aluResult,
   input  word_t   mdr,
   output word_t   rdA,
   output word_t   rdB
);

   word_t   regs [`MIPS_NREGS];
   regIdx_t wrIdx;
   word_t   wrData;

   // write-back selection
   assign wrIdx  = regDst ? rd : rt;          // R-format targets rd
   assign wrData = memToReg ? mdr : aluResult;

   always_ff @(posedge clk) begin
      if (write && wrIdx != '0)
         regs[wrIdx] <= wrData;
   end

   // register 0 is hardwired
   assign rdA = (rs == '0) ? '0 : regs[rs];
   assign rdB = (rt == '0) ? '0 : regs[rt];

endmodule

//--- src/mipsAlu.sv
`include "mips_consts.svh"

module mipsAlu
   import mipsIsaPkg::*, mipsCtrlPkg::*;
(
   input  aluOp_e op,
   input  word_t  a,
   input  word_t  b,
   output word_t  result,
   output logic   zero
);

   logic               sub;
   word_t              bIn;
   logic [`MIPS_XLEN:0] sum;   // extra bit is the carry out
   logic               ovf;
   logic               lessS;
   logic               lessU;

   // single adder, b inverted plus carry-in for everything but add
   assign sub = (op != opAdd);
   assign bIn = sub ? ~b : b;
   assign sum = {1'b0, a} + {1'b0, bIn} + {{`MIPS_XLEN{1'b0}}, sub};

   // a - b overflows when signs differ and the result sign flips
   assign ovf   = (a[`MIPS_XLEN-1] != b[`MIPS_XLEN-1]) &&
                  (a[`MIPS_XLEN-1] != sum[`MIPS_XLEN-1]);
   assign lessS = ovf ^ sum[`MIPS_XLEN-1];
   assign lessU = !sum[`MIPS_XLEN];   // borrow

   always_comb begin
      case (op)
         opAdd, opSub: result = sum[`MIPS_XLEN-1:0];
         opSlt:        result = word_t'(lessS);
         opSltu:       result = word_t'(lessU);
         opAnd:        result = a & b;
         opOr:         result = a | b;
         opNor:        result = ~(a | b);
         opXor:        result = a ^ b;
         opLui:        result = {b[15:0], 16'h0000};
         default:      result = '0;
      endcase
   end

   assign zero = (result == '0);

endmodule

//--- common/mipsCtrlPkg.sv
package mipsCtrlPkg;

   // controller sequence
   typedef enum logic [4:0] {
      rst,
      fetch1,
      fetch2,
      fetch3,
      decode,
      exAluR,
      exAluI,
      exLw1,
      exLw2,
      exLw3,
      exLw4,
      exLw5,
      exSw1,
      exSw2,
      exSw3,
      exBra1,
      exBra2,
      exJump,
      halt        // unknown opcode, never left
   } ctrlState_e;

   typedef enum logic [3:0] {
      opAdd  = 4'h0,
      opSub  = 4'h1,
      opSlt  = 4'h2,
      opSltu = 4'h3,
      opAnd  = 4'h4,
      opOr   = 4'h5,
      opNor  = 4'h6,
      opXor  = 4'h7,
      opLui  = 4'h8
   } aluOp_e;

   typedef enum logic {srcPc = 1'b0, srcRegA = 1'b1} aluSrcA_e;

   typedef enum logic [1:0] {
      srcRegB     = 2'b00,
      srcFour     = 2'b01,
      srcImm      = 2'b10,
      srcImmShift = 2'b11   // branch offset in words
   } aluSrcB_e;

   typedef enum logic {marPc = 1'b0, marAlu = 1'b1} marSrc_e;

endpackage

//--- common/mipsIsaPkg.sv
`include "mips_consts.svh"

package mipsIsaPkg;

   typedef logic [`MIPS_XLEN-1:0] word_t;
   typedef logic [`MIPS_RADDR-1:0] regIdx_t;

   // primary opcode, ir[31:26]
   typedef enum logic [5:0] {
      rFormat = 6'b000000,
      jump    = 6'b000010,
      beq     = 6'b000100,
      bne     = 6'b000101,
      addi    = 6'b001000,
      addiu   = 6'b001001,
      slti    = 6'b001010,
      sltiu   = 6'b001011,
      andi    = 6'b001100,
      ori     = 6'b001101,
      xori    = 6'b001110,
      lui     = 6'b001111,
      lw      = 6'b100011,
      sw      = 6'b101011
   } opcode_e;

   // R-format function field, ir[5:0]
   typedef enum logic [5:0] {
      fAdd  = 6'b100000,
      fAddu = 6'b100001,
      fSub  = 6'b100010,
      fSubu = 6'b100011,
      fAnd  = 6'b100100,
      fOr   = 6'b100101,
      fXor  = 6'b100110,
      fNor  = 6'b100111,
      fSlt  = 6'b101010,
      fSltu = 6'b101011
   } funct_e;

endpackage

//--- common/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// ---------------------------------------------------------------------------
// core widths
// ---------------------------------------------------------------------------
`define MIPS_XLEN 32           // data and address width
`define MIPS_RADDR 5           // register index width
`define MIPS_NREGS 32

// ---------------------------------------------------------------------------
// program counter
// ---------------------------------------------------------------------------
`define MIPS_RESET_PC 32'h0000_0000
`define MIPS_PC_STEP 32'd4     // one word per fetch

`endif
